// File: Makefile
# Verilator build for the rtc block
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= rtc_tb
FLIST     ?= rtc_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtc_top.f
+incdir+verilog
verilog/rtc_pkg.sv
verilog/rtc_cmd_deser.sv
verilog/rtc_timebase.sv
verilog/rtc_status_sender.sv
verilog/rtc_top.sv
verification/rtc_assertions.sv
verification/rtc_tb.sv

// File: verification/rtc_assertions.sv
// protocol checks for rtc_top, attached to every rtc_top by the bind below
// covers write strobes, status request hold and the packet header
`include "rtc_defs.svh"

module rtc_assertions (
    input logic       mclk,
    input logic       mrst,
    input logic       cmd_we,
    input logic       load_req,
    input logic       snap,
    input logic       status_rq,
    input logic       status_start,
    input logic [7:0] status_ad
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count;     // assertion failures so far

    initial fail_count = 0;

    // strobes last one cycle only
    a_we_pulse: assert property (@(posedge mclk) disable iff (mrst) cmd_we |=> !cmd_we)
        else begin
            $error("cmd_we held longer than one cycle");
            fail_count++;
        end
    a_load_pulse: assert property (@(posedge mclk) disable iff (mrst) load_req |=> !load_req)
        else begin
            $error("load_req held longer than one cycle");
            fail_count++;
        end
    a_snap_pulse: assert property (@(posedge mclk) disable iff (mrst) snap |=> !snap)
        else begin
            $error("snap held longer than one cycle");
            fail_count++;
        end

    // request holds until the acknowledge, then drops
    a_rq_hold: assert property (@(posedge mclk) disable iff (mrst)
        status_rq && !status_start |=> status_rq)
        else begin
            $error("status_rq dropped without status_start");
            fail_count++;
        end
    a_rq_drop: assert property (@(posedge mclk) disable iff (mrst)
        status_rq && status_start |=> !status_rq)
        else begin
            $error("status_rq still high after status_start");
            fail_count++;
        end
    a_header: assert property (@(posedge mclk) disable iff (mrst)
        status_rq |-> status_ad == 8'(`RTC_STATUS_ADDR))
        else begin
            $error("status_ad is not the header while status_rq is high");
            fail_count++;
        end

    // reset leaves no strobe or request behind
    a_reset: assert property (@(posedge mclk) mrst |=> !status_rq && !cmd_we && !snap)
        else begin
            $error("strobe or request active right after reset");
            fail_count++;
        end

endmodule

bind rtc_top rtc_assertions i_assertions (
    .mclk         (mclk),
    .mrst         (mrst),
    .cmd_we       (cmd_we),
    .load_req     (load_req),
    .snap         (snap),
    .status_rq    (status_rq),
    .status_start (status_start),
    .status_ad    (status_ad)
);

// File: verification/rtc_tb.sv
// testbench for rtc_top
// drives commands and a 25 MHz refclk, captures status packets and checks
// load, rate, rollover, correction and address decode
`include "rtc_defs.svh"

module rtc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 5000;           // cycles per handshake wait
    localparam logic [15:0] BASE = 16'(`RTC_CMD_ADDR);

    logic           mclk;
    logic           mrst;
    logic           refclk;
    logic [7:0]     cmd_ad;
    logic           cmd_stb;
    logic           status_start;
    logic [7:0]     status_ad;
    logic           status_rq;
    rtc_pkg::sec_t  live_sec;
    rtc_pkg::usec_t live_usec;

    int          errors;
    int          timeouts;
    logic [7:0]  pkt [9];                       // captured status bytes
    event        pkt_done;
    logic [5:0]  exp_seq;
    logic        exp_alt;
    longint      t_before;                      // live time just before the snap
    logic [5:0]  chk_seq;                       // expectations of the captured packet
    logic        chk_alt;
    longint      chk_t_before;
    longint      t_a;
    longint      t_b;
    longint      t0;
    int          n;
    logic [15:0] corr_v;
    rtc_pkg::sec_t s_val;

    rtc_top i_dut (
        .mclk         (mclk),
        .mrst         (mrst),
        .refclk       (refclk),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .status_start (status_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .live_sec     (live_sec),
        .live_usec    (live_usec)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    initial begin
        refclk = 1'b0;
        forever #20 refclk = ~refclk;           // both edges, 50 per usec
    end

    // carries of a 24-bit accumulator stepping by 2^23 + corr per tick
    function automatic int expected_incs(input logic signed [15:0] corr, input int ticks);
        longint acc;
        longint step;
        int     cnt;
        acc  = 0;
        cnt  = 0;
        step = 64'd8388608 + longint'(corr);
        for (int i = 0; i < ticks; i++) begin
            acc = acc + step;
            if (acc >= 64'd16777216) begin
                cnt++;
                acc = acc - 64'd16777216;
            end
        end
        return cnt;
    endfunction

    function automatic longint total_usec(input logic [31:0] s, input logic [19:0] u);
        return longint'(s) * 1000000 + longint'(u);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_range(input string what, input longint val, input longint lo,
                               input longint hi);
        assert (val >= lo && val <= hi) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h to %h", what, val, lo, hi);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout: %s did not happen in time", what);
    endtask

    // six bytes on consecutive falling edges
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        @(negedge mclk);
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        for (int k = 0; k < 4; k++) begin
            @(negedge mclk);
            cmd_ad = data[8*k +: 8];
        end
        @(negedge mclk);
        cmd_ad = 8'h00;
        repeat (3) @(negedge mclk);             // strobe and snap have passed
    endtask

    task automatic wait_sec(input logic [31:0] target);
        int cnt;
        cnt = 0;
        while (live_sec !== target && cnt < WAIT_LIMIT) begin
            @(negedge mclk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) note_timeout("live_sec reaching the expected value");
    endtask

    task automatic capture_packet();
        int cnt;
        cnt = 0;
        while (status_rq !== 1'b1 && cnt < WAIT_LIMIT) begin
            @(negedge mclk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            note_timeout("status_rq");
        end else begin
            status_start = 1'b1;
            pkt[0] = status_ad;                 // header while requesting
            @(negedge mclk);
            status_start = 1'b0;
            pkt[1] = status_ad;
            for (int k = 2; k < 9; k++) begin
                @(negedge mclk);
                pkt[k] = status_ad;
            end
            chk_seq      = exp_seq;
            chk_alt      = exp_alt;
            chk_t_before = t_before;
            -> pkt_done;
        end
    endtask

    task automatic status_request(input logic [5:0] seq);
        exp_seq  = seq;
        exp_alt  = ~exp_alt;                    // alt flips on every snap
        t_before = total_usec(live_sec, live_usec);
        send_cmd(BASE + 16'd3, {26'h0, seq});
        capture_packet();
    endtask

    function automatic longint packet_time();
        return total_usec({pkt[5], pkt[4], pkt[3], pkt[2]}, {pkt[8][3:0], pkt[7], pkt[6]});
    endfunction

    // comparing process for every captured packet
    initial begin
        forever begin
            @(pkt_done);
            check_val("status_ad header", 32'(pkt[0]), 32'(`RTC_STATUS_ADDR));
            check_val("status_ad seq_alt", 32'(pkt[1]), 32'({chk_seq, chk_alt, 1'b0}));
            check_val("status_ad usec_hi", 32'(pkt[8][7:4]), 32'h0);
            check_range("status_ad snapshot time after request",
                        packet_time() - chk_t_before, 0, 1);
        end
    end

    initial begin
        #3000000;
        $display("errors %0d timeouts %0d, overall time limit reached", errors, timeouts);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h3197d218));
        errors       = 0;
        timeouts     = 0;
        exp_alt      = 1'b0;
        mrst         = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        repeat (10) @(negedge mclk);
        mrst = 1'b0;

        // idle after reset, nothing runs without a load
        send_cmd(BASE + 16'd2, 32'h0);
        repeat (1500) @(negedge mclk);
        check_val("live_sec", live_sec, 32'h0);
        check_val("live_usec", 32'(live_usec), 32'h0);
        check_val("status_rq", 32'(status_rq), 32'h0);

        // load and nominal rate
        s_val = 32'h12345678;
        send_cmd(BASE, 32'd1000);
        send_cmd(BASE + 16'd1, s_val);
        wait_sec(s_val);
        check_val("live_usec", 32'(live_usec), 32'd1000);
        t0 = total_usec(live_sec, live_usec);
        repeat (25000) @(negedge mclk);         // 100 us
        check_range("live_usec advance at corr 0",
                    total_usec(live_sec, live_usec) - t0, 99, 101);

        // foreign addresses are ignored
        t0 = total_usec(live_sec, live_usec);
        send_cmd(BASE + 16'd5, 32'hdeadbeef);
        send_cmd(BASE + 16'd6, 32'h00007fff);
        send_cmd(BASE + 16'd7, 32'h0000002a);
        check_val("status_rq", 32'(status_rq), 32'h0);
        repeat (250000) @(negedge mclk);        // 1 ms
        check_val("live_sec", live_sec, s_val);
        check_range("live_usec advance after foreign writes",
                    total_usec(live_sec, live_usec) - t0, 999, 1001);

        // second rollover
        s_val = 32'h000000ff;
        send_cmd(BASE, 32'(`RTC_USEC_MAX - 5));
        send_cmd(BASE + 16'd1, s_val);
        wait_sec(s_val);
        wait_sec(s_val + 1);
        check_range("live_usec after wrap", longint'(live_usec), 0, 1);
        repeat (2500) @(negedge mclk);          // 10 us
        check_val("live_sec", live_sec, s_val + 1);
        check_range("live_usec 10 us after wrap", longint'(live_usec), 9, 11);

        // random correction measured between two status packets
        corr_v = 16'($urandom);
        send_cmd(BASE + 16'd2, {16'h0, corr_v});
        status_request(6'($urandom));
        t_a = packet_time();
        repeat (250000) @(negedge mclk);        // 2000 ticks
        status_request(6'($urandom));
        t_b = packet_time();
        n = expected_incs(signed'(corr_v), 2000);
        check_range("live_usec increments with correction", t_b - t_a, n - 2, n + 2);
        status_request(6'($urandom));

        repeat (10) @(negedge mclk);
        $display("errors %0d timeouts %0d assertion failures %0d",
                 errors, timeouts, i_dut.i_assertions.fail_count);
        if (errors == 0 && timeouts == 0 && i_dut.i_assertions.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/rtc_cmd_deser.sv
// deserializer for the six-byte command packets of the rtc
// bytes AL AH D0 D1 D2 D3 follow cmd_stb on consecutive cycles
// cmd_we pulses the cycle after D3 when the masked address matches
`include "rtc_defs.svh"

module rtc_cmd_deser (
    input  logic              mclk,
    input  logic              mrst,
    input  logic [7:0]        cmd_ad,
    input  logic              cmd_stb,
    output logic              cmd_we,
    output rtc_pkg::reg_sel_t cmd_sel,
    output logic [31:0]       cmd_data
);

    logic [4:0]  pos;           // one-hot, bit 0 on AH ... bit 4 on D3
    logic [7:0]  addr_lo;       // AL, kept for the select bits
    logic [15:0] addr_full;     // AH:AL during pos[0]
    logic        addr_ok;       // masked compare result
    logic [23:0] data_sr;       // D0..D2, lsb byte first

    assign addr_full = {cmd_ad, addr_lo};

    // position and strobe
    always_ff @(posedge mclk) begin
        if (mrst) begin
            pos     <= '0;
            addr_ok <= 1'b0;
            cmd_we  <= 1'b0;
        end else begin
            pos <= {pos[3:0], cmd_stb};
            if (pos[0]) begin
                addr_ok <= (addr_full & 16'(`RTC_CMD_MASK)) ==
                           (16'(`RTC_CMD_ADDR) & 16'(`RTC_CMD_MASK));
            end
            cmd_we <= pos[4] & addr_ok;     // one cycle after the last byte
        end
    end

    // payload capture
    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            addr_lo <= cmd_ad;
        end
        if (|pos[3:1]) begin
            data_sr <= {cmd_ad, data_sr[23:8]};     // shift in from the top
        end
        if (pos[4] && addr_ok) begin
            cmd_data <= {cmd_ad, data_sr};          // D3 completes the word
            cmd_sel  <= rtc_pkg::reg_sel_t'(addr_lo[1:0]);
        end
    end

endmodule

// File: verilog/rtc_defs.svh
// address map and timing constants for the rtc block
// include in every rtc file that compares addresses or counts refclk edges
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

// command slave decode, four registers from the base
`define RTC_CMD_ADDR 'h704      // usec, sec, corr, status
`define RTC_CMD_MASK 'h7fc      // low two bits pick the register

// first byte of every status packet
`define RTC_STATUS_ADDR 'h31

// reference clock in MHz
// both edges are counted, so this is also the edge count per half microsecond
`define RTC_MHZ 25

// prescaler width, must hold RTC_MHZ-1
`define RTC_PREDIV_BITS 5

// last usec value before the seconds roll over
`define RTC_USEC_MAX 999999

`endif

// File: verilog/rtc_pkg.sv
// shared types for the rtc block
// register selects and time value widths, used by scoped name only
package rtc_pkg;

    localparam int USEC_W = 20;     // enough for 999999
    localparam int SEC_W  = 32;
    localparam int CORR_W = 16;

    // low two bits of the command address
    typedef enum logic [1:0] {
        REG_USEC   = 2'd0,          // pending microseconds
        REG_SEC    = 2'd1,          // seconds, also loads the counter
        REG_CORR   = 2'd2,          // signed rate trim
        REG_STATUS = 2'd3           // snapshot + status request
    } reg_sel_t;

    typedef logic [USEC_W-1:0]        usec_t;
    typedef logic [SEC_W-1:0]         sec_t;
    typedef logic signed [CORR_W-1:0] corr_t;

endpackage

// File: verilog/rtc_status_sender.sv
// status packet sender for the rtc
// snap latches the time, then status_rq waits for status_start and
// nine bytes go out: header, {seq,alt,0}, sec[31:0], usec[19:0]
`include "rtc_defs.svh"

module rtc_status_sender (
    input  logic           mclk,
    input  logic           mrst,
    input  logic           snap,
    input  logic [5:0]     seq,
    input  rtc_pkg::usec_t snap_usec,
    input  rtc_pkg::sec_t  snap_sec,
    input  logic           status_start,
    output logic           status_rq,
    output logic [7:0]     status_ad
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,                        // header shown, waiting for status_start
        SEND                        // payload bytes 1..8
    } state_t;

    state_t         state;
    logic [3:0]     idx;            // byte index within the packet
    logic           alt;            // flips on every snap
    logic           pend;           // snap seen while sending
    logic [5:0]     hold_seq;       // latest snapshot
    rtc_pkg::usec_t hold_usec;
    rtc_pkg::sec_t  hold_sec;
    logic [5:0]     tx_seq;         // copy being sent
    logic           tx_alt;
    rtc_pkg::usec_t tx_usec;
    rtc_pkg::sec_t  tx_sec;

    assign status_rq = (state == REQ);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state <= IDLE;
            idx   <= '0;
            alt   <= 1'b0;
            pend  <= 1'b0;
        end else begin
            if (snap) alt <= ~alt;
            case (state)
                IDLE: if (snap) state <= REQ;
                REQ: if (status_start) begin
                    state <= SEND;
                    idx   <= 4'd1;
                    if (snap) pend <= 1'b1;     // snap together with the header byte
                end
                default: begin
                    idx <= idx + 1'b1;
                    if (snap) pend <= 1'b1;     // serve after this packet
                    if (idx == 4'd8) begin
                        state <= (pend || snap) ? REQ : IDLE;
                        pend  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (snap) begin
            hold_seq  <= seq;
            hold_usec <= snap_usec;
            hold_sec  <= snap_sec;
        end
        if (state == REQ && status_start) begin
            tx_seq  <= hold_seq;
            tx_alt  <= alt;
            tx_usec <= hold_usec;
            tx_sec  <= hold_sec;
        end
    end

    // byte mux
    always_comb begin
        status_ad = 8'h00;
        if (state == REQ) begin
            status_ad = 8'(`RTC_STATUS_ADDR);
        end else if (state == SEND) begin
            case (idx)
                4'd1:    status_ad = {tx_seq, tx_alt, 1'b0};
                4'd2:    status_ad = tx_sec[7:0];
                4'd3:    status_ad = tx_sec[15:8];
                4'd4:    status_ad = tx_sec[23:16];
                4'd5:    status_ad = tx_sec[31:24];
                4'd6:    status_ad = tx_usec[7:0];
                4'd7:    status_ad = tx_usec[15:8];
                default: status_ad = {4'h0, tx_usec[19:16]};
            endcase
        end
    end

endmodule

// File: verilog/rtc_timebase.sv
// rtc counter core, seconds and microseconds driven from refclk
// both refclk edges feed a prescaler, every half usec a 24-bit accumulator
// adds 2^23 + corr, its carry advances the usec count
`include "rtc_defs.svh"

module rtc_timebase (
    input  logic           mclk,
    input  logic           mrst,
    input  logic           refclk,
    input  logic           load_req,
    input  rtc_pkg::usec_t wusec,
    input  rtc_pkg::sec_t  wsec,
    input  rtc_pkg::corr_t corr,
    output rtc_pkg::usec_t live_usec,
    output rtc_pkg::sec_t  live_sec
);

    logic [2:0]                    refclk_sync;    // refclk into mclk
    logic                          refclk2x;       // one pulse per refclk edge
    logic [`RTC_PREDIV_BITS-1:0]   pre_cntr;
    logic                          tick;           // half usec boundary
    logic [3:0]                    ring;           // one-hot phase after tick
    logic                          enable;
    logic                          pend_load;      // waiting for phase 3
    logic [23:0]                   acc;
    logic [23:0]                   acc_step;       // 2^23 + sign-extended corr
    logic [24:0]                   next_acc;
    logic [1:0]                    inc_usec;       // carry pipeline
    logic [1:0]                    inc_sec;
    rtc_pkg::usec_t                usec;
    rtc_pkg::sec_t                 sec;
    rtc_pkg::usec_t                usec_plus1;
    rtc_pkg::sec_t                 sec_plus1;

    assign acc_step = 24'h800000 + {{8{corr[15]}}, corr};
    assign next_acc = {1'b0, acc} + {1'b0, acc_step};
    assign tick     = enable && refclk2x && (pre_cntr == '0);

    assign live_usec = usec;
    assign live_sec  = sec;

    // refclk edge detect and prescaler
    always_ff @(posedge mclk) begin
        if (mrst) begin
            refclk_sync <= '0;
            refclk2x    <= 1'b0;
        end else begin
            refclk_sync <= {refclk_sync[1:0], refclk};
            refclk2x    <= refclk_sync[2] ^ refclk_sync[1];   // either edge
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst || !enable) begin
            pre_cntr <= `RTC_PREDIV_BITS'(`RTC_MHZ - 1);
            ring     <= '0;
        end else begin
            if (refclk2x) begin
                pre_cntr <= (pre_cntr == '0) ? `RTC_PREDIV_BITS'(`RTC_MHZ - 1)
                                             : pre_cntr - 1'b1;
            end
            ring <= {ring[2:0], tick};
        end
    end

    // enable and pending load
    always_ff @(posedge mclk) begin
        if (mrst) begin
            enable    <= 1'b0;
            pend_load <= 1'b0;
        end else begin
            if (load_req) enable <= 1'b1;   // runs from the first load on
            if (load_req) begin
                pend_load <= 1'b1;
            end else if (ring[3]) begin
                pend_load <= 1'b0;          // consumed at phase 3
            end
        end
    end

    // accumulator, increments and counters
    always_ff @(posedge mclk) begin
        if (mrst) begin
            acc      <= '0;
            inc_usec <= '0;
            inc_sec  <= '0;
            usec     <= '0;
            sec      <= '0;
        end else begin
            if (ring[3] && pend_load) begin
                acc <= '0;                  // load restarts the fraction
            end else if (ring[1]) begin
                acc <= next_acc[23:0];
            end
            inc_usec <= {inc_usec[0], ring[1] & next_acc[24]};
            inc_sec  <= {inc_sec[0], ring[1] & next_acc[24] &
                         (usec == rtc_pkg::USEC_W'(`RTC_USEC_MAX))};
            if (ring[3] && pend_load) begin
                usec <= wusec;              // load beats a carry in flight
                sec  <= wsec;
            end else if (inc_sec[1]) begin
                usec <= '0;                 // wrap at RTC_USEC_MAX
                sec  <= sec_plus1;
            end else if (inc_usec[1]) begin
                usec <= usec_plus1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        usec_plus1 <= usec + 1'b1;          // precomputed, off the mux path
        sec_plus1  <= sec + 1'b1;
    end

endmodule

// File: verilog/rtc_top.sv
// top level of the adjustable real-time clock
// decodes command writes into the usec, sec and corr registers,
// starts loads and status snapshots
module rtc_top (
    input  logic           mclk,
    input  logic           mrst,
    input  logic           refclk,
    input  logic [7:0]     cmd_ad,
    input  logic           cmd_stb,
    input  logic           status_start,
    output logic [7:0]     status_ad,
    output logic           status_rq,
    output rtc_pkg::sec_t  live_sec,
    output rtc_pkg::usec_t live_usec
);

    logic              cmd_we;
    rtc_pkg::reg_sel_t cmd_sel;
    logic [31:0]       cmd_data;
    rtc_pkg::usec_t    wusec;       // pending usec for the next load
    rtc_pkg::sec_t     wsec;
    rtc_pkg::corr_t    corr;
    logic              load_req;    // one cycle after a SEC write
    logic              snap;        // one cycle after a STATUS write
    logic [5:0]        seq;

    assign seq = cmd_data[5:0];     // held until the next command

    always_ff @(posedge mclk) begin
        if (cmd_we && cmd_sel == rtc_pkg::REG_USEC) wusec <= cmd_data[19:0];
        if (cmd_we && cmd_sel == rtc_pkg::REG_SEC)  wsec  <= cmd_data;
        if (cmd_we && cmd_sel == rtc_pkg::REG_CORR) corr  <= signed'(cmd_data[15:0]);
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            load_req <= 1'b0;
            snap     <= 1'b0;
        end else begin
            load_req <= cmd_we && (cmd_sel == rtc_pkg::REG_SEC);
            snap     <= cmd_we && (cmd_sel == rtc_pkg::REG_STATUS);
        end
    end

    rtc_cmd_deser i_deser (
        .mclk     (mclk),
        .mrst     (mrst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_we   (cmd_we),
        .cmd_sel  (cmd_sel),
        .cmd_data (cmd_data)
    );

    rtc_timebase i_timebase (
        .mclk      (mclk),
        .mrst      (mrst),
        .refclk    (refclk),
        .load_req  (load_req),
        .wusec     (wusec),
        .wsec      (wsec),
        .corr      (corr),
        .live_usec (live_usec),
        .live_sec  (live_sec)
    );

    rtc_status_sender i_status (
        .mclk         (mclk),
        .mrst         (mrst),
        .snap         (snap),
        .seq          (seq),
        .snap_usec    (live_usec),
        .snap_sec     (live_sec),
        .status_start (status_start),
        .status_rq    (status_rq),
        .status_ad    (status_ad)
    );

endmodule
